//--- cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // ********************
    // line geometry
    // ********************
    localparam int LINE_BYTES     = 32;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = LINE_BYTES * 8 / WORD_BITS;
    localparam int OFFSET_BITS    = $clog2(LINE_BYTES);   // byte offset within a line

    // one cache line, word view for loads, byte view for store merge
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] words;
        logic [LINE_BYTES-1:0][7:0]               bytes;
    } line_u;

    typedef logic way_t;   // way number, two ways

endpackage

`default_nettype wire

//--- mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;
    import cache_geom_pkg::*;

    // core request, one word per access
    typedef struct packed {
        logic                   valid;
        logic                   is_store;
        logic [31:0]            addr;
        logic [WORD_BITS-1:0]   wdata;
        logic [WORD_BITS/8-1:0] strb;      // byte strobes for stores
    } cpu_req_t;

    // ********************
    // memory side, line sized
    // ********************
    typedef struct packed {
        logic        ren;
        logic [31:0] raddr;   // line aligned
    } mem_rd_t;

    typedef struct packed {
        logic [3:0]  wen;
        logic [31:0] waddr;
        line_u       wdata;
    } mem_wr_t;

endpackage

`default_nettype wire

//--- dcache_way_ram.sv
`default_nettype none

module dcache_way_ram #(
    parameter  int SET_BITS = 7,
    localparam int TAG_W    = 33 - SET_BITS - cache_geom_pkg::OFFSET_BITS
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [SET_BITS-1:0]         rd_index,
    input  wire [SET_BITS-1:0]         wr_index,
    input  wire                        wr_tag_en,
    input  wire [31:0]                 byte_en,
    input  wire [TAG_W-1:0]            wr_tag,
    input  wire cache_geom_pkg::line_u wr_line,
    output logic [TAG_W-1:0]           tag,
    output cache_geom_pkg::line_u      line
);
    import cache_geom_pkg::*;

    localparam int SETS = 1 << SET_BITS;

    logic [SETS-1:0]     valid_q;
    logic [TAG_W-2:0]    tag_mem [SETS];
    line_u               data_mem [SETS];
    logic [TAG_W-1:0]    tag_rd;
    line_u               line_rd;
    logic [SET_BITS-1:0] rd_index_q;
    logic [SET_BITS-1:0] wr_index_q;
    logic                tag_we_q;
    logic                line_we_q;
    logic [TAG_W-1:0]    tag_q;
    line_u               line_q;

    // ********************
    // storage arrays
    // ********************
    always_ff @(posedge clk)
    begin
        if (wr_tag_en)
            tag_mem[wr_index] <= wr_tag[TAG_W-2:0];
        for (int b = 0; b < LINE_BYTES; b++)
        begin
            if (byte_en[b])
                data_mem[wr_index].bytes[b] <= wr_line.bytes[b];
        end
        tag_rd     <= {valid_q[rd_index], tag_mem[rd_index]};   // old content on collision
        line_rd    <= data_mem[rd_index];
        rd_index_q <= rd_index;
        wr_index_q <= wr_index;
        tag_q      <= wr_tag;
        line_q     <= wr_line;   // full line, store data already merged
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q   <= '0;
            tag_we_q  <= 1'b0;
            line_we_q <= 1'b0;
        end
        else
        begin
            if (wr_tag_en)
                valid_q[wr_index] <= wr_tag[TAG_W-1];
            tag_we_q  <= wr_tag_en;
            line_we_q <= |byte_en;
        end
    end

    // write-first forwarding of the last write
    assign tag  = (tag_we_q && rd_index_q == wr_index_q) ? tag_q : tag_rd;
    assign line = (line_we_q && rd_index_q == wr_index_q) ? line_q : line_rd;

endmodule

`default_nettype wire

//--- dcache_lookup.sv
`default_nettype none

module dcache_lookup #(
    parameter int SET_BITS = 7
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire mem_bus_pkg::cpu_req_t req,
    input  wire                        stall,
    output mem_bus_pkg::cpu_req_t      stage,
    output logic [SET_BITS-1:0]        rd_index
);
    import cache_geom_pkg::*;

    logic [SET_BITS-1:0] req_set;
    logic [SET_BITS-1:0] stage_set;

    assign req_set   = req.addr[OFFSET_BITS +: SET_BITS];
    assign stage_set = stage.addr[OFFSET_BITS +: SET_BITS];

    // ********************
    // request stage
    // ********************
    always_ff @(posedge clk)
    begin
        if (!stall)
            stage <= req;   // payload follows the request
        if (rst)
            stage.valid <= 1'b0;
    end

    // while stalled the staged set is read again, so a refill shows up
    always_comb
    begin
        if (stall)
            rd_index = stage_set;
        else
            rd_index = req_set;
    end

endmodule

`default_nettype wire

//--- dcache_hit_stage.sv
`default_nettype none

module dcache_hit_stage #(
    parameter  int SET_BITS = 7,
    localparam int TAG_W    = 33 - SET_BITS - cache_geom_pkg::OFFSET_BITS
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire mem_bus_pkg::cpu_req_t stage,
    input  wire [TAG_W-1:0]            tag0,
    input  wire [TAG_W-1:0]            tag1,
    input  wire cache_geom_pkg::line_u line0,
    input  wire cache_geom_pkg::line_u line1,
    input  wire                        refill,
    input  wire cache_geom_pkg::way_t  refill_way,
    input  wire cache_geom_pkg::line_u mem_rdata,
    output logic                       hit,
    output cache_geom_pkg::way_t       hit_way,
    output logic                       tag_en0,
    output logic                       tag_en1,
    output logic [31:0]                byte_en0,
    output logic [31:0]                byte_en1,
    output cache_geom_pkg::line_u      wr_line,
    output logic [31:0]                rdata,
    output logic                       rdata_valid
);
    import cache_geom_pkg::*;

    logic [TAG_W-1:0]       cmp_tag;
    logic                   hit0;
    logic                   hit1;
    logic [OFFSET_BITS-3:0] word_off;
    line_u                  hit_line;
    line_u                  store_line;
    line_u                  merged;
    logic [LINE_BYTES-1:0]  byte_mask;
    logic                   store_we;
    logic                   refill_q;

    assign cmp_tag  = {1'b1, stage.addr[31 -: TAG_W-1]};   // valid bit + address tag
    assign hit0     = stage.valid && tag0 == cmp_tag;
    assign hit1     = stage.valid && tag1 == cmp_tag;
    assign hit      = hit0 || hit1;
    assign hit_way  = hit1;
    assign hit_line = hit1 ? line1 : line0;
    assign word_off = stage.addr[OFFSET_BITS-1:2];

    // ********************
    // store merge
    // ********************
    assign byte_mask  = LINE_BYTES'(stage.strb) << {word_off, 2'b00};
    assign store_line = {WORDS_PER_LINE{stage.wdata}};   // store word in every slot

    always_comb
    begin
        for (int b = 0; b < LINE_BYTES; b++)
            merged.bytes[b] = byte_mask[b] ? store_line.bytes[b] : hit_line.bytes[b];
    end

    // the cycle after a refill sees the forwarded line, controller still busy
    assign store_we = hit && stage.is_store && !refill_q;
    assign tag_en0  = refill && !refill_way;
    assign tag_en1  = refill && refill_way;
    assign byte_en0 = tag_en0 ? '1 : ((store_we && !hit_way) ? byte_mask : '0);
    assign byte_en1 = tag_en1 ? '1 : ((store_we && hit_way) ? byte_mask : '0);
    assign wr_line  = refill ? mem_rdata : merged;

    always_ff @(posedge clk)
    begin
        if (hit && !stage.is_store)
            rdata <= hit_line.words[word_off];
        if (rst)
        begin
            rdata_valid <= 1'b0;
            refill_q    <= 1'b0;
        end
        else
        begin
            rdata_valid <= hit && !stage.is_store && !refill_q;
            refill_q    <= refill;   // high in the REFILL cycle
        end
    end

endmodule

`default_nettype wire

//--- dcache_miss_ctrl.sv
`default_nettype none

module dcache_miss_ctrl #(
    parameter  int SET_BITS = 7,
    localparam int TAG_W    = 33 - SET_BITS - cache_geom_pkg::OFFSET_BITS
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire mem_bus_pkg::cpu_req_t stage,
    input  wire                        hit,
    input  wire cache_geom_pkg::way_t  hit_way,
    input  wire [TAG_W-1:0]            tag0,
    input  wire [TAG_W-1:0]            tag1,
    input  wire cache_geom_pkg::line_u line0,
    input  wire cache_geom_pkg::line_u line1,
    output logic                       ready,
    output logic                       refill,
    output cache_geom_pkg::way_t       refill_way,
    output mem_bus_pkg::mem_rd_t       mem_rd,
    input  wire                        mem_rrdy,
    input  wire                        mem_ren_received,
    input  wire                        mem_rvalid,
    output mem_bus_pkg::mem_wr_t       mem_wr,
    input  wire                        mem_wrdy,
    input  wire                        mem_write_finish
);
    import cache_geom_pkg::*;

    localparam int SETS = 1 << SET_BITS;

    typedef enum logic [1:0] {IDLE, WRITEBACK, FETCH, REFILL} state_t;

    state_t               state;
    state_t               next_state;
    logic [SETS-1:0]      use_q;      // way to replace next
    logic [SETS-1:0][1:0] dirty_q;
    logic [SET_BITS-1:0]  set;
    way_t                 victim;
    logic [TAG_W-2:0]     victim_tag;
    logic                 miss;
    logic                 wr_sent;
    logic                 rd_sent;

    assign set        = stage.addr[OFFSET_BITS +: SET_BITS];
    assign victim     = use_q[set];
    assign victim_tag = victim ? tag1[TAG_W-2:0] : tag0[TAG_W-2:0];
    assign refill_way = victim;
    assign miss       = stage.valid && !hit;
    assign refill     = state == FETCH && mem_rvalid;
    assign ready      = state == IDLE && !miss;

    // ********************
    // miss FSM
    // ********************
    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (miss)
                    next_state = dirty_q[set][victim] ? WRITEBACK : FETCH;
            WRITEBACK:
                if (wr_sent && mem_write_finish)
                    next_state = FETCH;
            FETCH:
                if (mem_rvalid)
                    next_state = REFILL;
            default:
                next_state = IDLE;   // REFILL, one cycle
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == WRITEBACK && mem_wrdy && !wr_sent)
        begin
            mem_wr.waddr <= {victim_tag, set, {OFFSET_BITS{1'b0}}};
            mem_wr.wdata <= victim ? line1 : line0;
        end
        if (state == FETCH && mem_rrdy && !rd_sent)
            mem_rd.raddr <= {stage.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        if (rst)
        begin
            state      <= IDLE;
            use_q      <= '0;
            dirty_q    <= '0;
            wr_sent    <= 1'b0;
            rd_sent    <= 1'b0;
            mem_rd.ren <= 1'b0;
            mem_wr.wen <= '0;
        end
        else
        begin
            state      <= next_state;
            mem_wr.wen <= '0;   // single cycle pulse
            if (state == IDLE && stage.valid && hit)
            begin
                use_q[set] <= !hit_way;
                if (stage.is_store)
                    dirty_q[set][hit_way] <= 1'b1;
            end
            if (state == WRITEBACK)
            begin
                if (mem_wrdy && !wr_sent)
                begin
                    mem_wr.wen <= '1;
                    wr_sent    <= 1'b1;
                end
                if (wr_sent && mem_write_finish)
                    wr_sent <= 1'b0;
            end
            if (state == FETCH)
            begin
                if (mem_rrdy && !rd_sent)
                begin
                    mem_rd.ren <= 1'b1;
                    rd_sent    <= 1'b1;
                end
                else if (mem_ren_received)
                    mem_rd.ren <= 1'b0;
                if (mem_rvalid)
                begin
                    mem_rd.ren           <= 1'b0;
                    rd_sent              <= 1'b0;
                    dirty_q[set][victim] <= 1'b0;   // fresh line is clean
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_top.sv
`default_nettype none

module dcache_top #(
    parameter  int SET_BITS = 7,
    localparam int TAG_W    = 33 - SET_BITS - cache_geom_pkg::OFFSET_BITS
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire mem_bus_pkg::cpu_req_t req,
    output logic                       ready,
    output logic [31:0]                rdata,
    output logic                       rdata_valid,
    output mem_bus_pkg::mem_rd_t       mem_rd,
    input  wire                        mem_rrdy,
    input  wire                        mem_ren_received,
    input  wire                        mem_rvalid,
    input  wire cache_geom_pkg::line_u mem_rdata,
    output mem_bus_pkg::mem_wr_t       mem_wr,
    input  wire                        mem_wrdy,
    input  wire                        mem_write_finish
);
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    cpu_req_t            stage;
    logic                stall;
    logic [SET_BITS-1:0] rd_index;
    logic [SET_BITS-1:0] wr_index;
    logic [TAG_W-1:0]    wr_tag;
    logic [TAG_W-1:0]    tag0;
    logic [TAG_W-1:0]    tag1;
    line_u               line0;
    line_u               line1;
    line_u               wr_line;
    logic                hit;
    way_t                hit_way;
    logic                tag_en0;
    logic                tag_en1;
    logic [31:0]         byte_en0;
    logic [31:0]         byte_en1;
    logic                refill;
    way_t                refill_way;

    assign stall    = !ready;   // lookup holds while the controller is busy
    assign wr_index = stage.addr[OFFSET_BITS +: SET_BITS];
    assign wr_tag   = {1'b1, stage.addr[31 -: TAG_W-1]};

    // ********************
    // pipeline
    // ********************
    dcache_lookup #(.SET_BITS(SET_BITS)) lookup_i (
        .clk(clk), .rst(rst), .req(req), .stall(stall), .stage(stage), .rd_index(rd_index)
    );

    dcache_way_ram #(.SET_BITS(SET_BITS)) way0_i (
        .clk(clk), .rst(rst), .rd_index(rd_index), .wr_index(wr_index),
        .wr_tag_en(tag_en0), .byte_en(byte_en0), .wr_tag(wr_tag), .wr_line(wr_line),
        .tag(tag0), .line(line0)
    );

    dcache_way_ram #(.SET_BITS(SET_BITS)) way1_i (
        .clk(clk), .rst(rst), .rd_index(rd_index), .wr_index(wr_index),
        .wr_tag_en(tag_en1), .byte_en(byte_en1), .wr_tag(wr_tag), .wr_line(wr_line),
        .tag(tag1), .line(line1)
    );

    dcache_hit_stage #(.SET_BITS(SET_BITS)) hit_i (
        .clk(clk), .rst(rst), .stage(stage), .tag0(tag0), .tag1(tag1),
        .line0(line0), .line1(line1), .refill(refill), .refill_way(refill_way),
        .mem_rdata(mem_rdata), .hit(hit), .hit_way(hit_way),
        .tag_en0(tag_en0), .tag_en1(tag_en1), .byte_en0(byte_en0), .byte_en1(byte_en1),
        .wr_line(wr_line), .rdata(rdata), .rdata_valid(rdata_valid)
    );

    dcache_miss_ctrl #(.SET_BITS(SET_BITS)) miss_i (
        .clk(clk), .rst(rst), .stage(stage), .hit(hit), .hit_way(hit_way),
        .tag0(tag0), .tag1(tag1), .line0(line0), .line1(line1),
        .ready(ready), .refill(refill), .refill_way(refill_way),
        .mem_rd(mem_rd), .mem_rrdy(mem_rrdy), .mem_ren_received(mem_ren_received),
        .mem_rvalid(mem_rvalid), .mem_wr(mem_wr), .mem_wrdy(mem_wrdy),
        .mem_write_finish(mem_write_finish)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`default_nettype none

module tb_mem_model (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mem_bus_pkg::mem_rd_t mem_rd,
    output logic                      mem_rrdy,
    output logic                      mem_ren_received,
    output logic                      mem_rvalid,
    output cache_geom_pkg::line_u     mem_rdata,
    input  wire mem_bus_pkg::mem_wr_t mem_wr,
    output logic                      mem_wrdy,
    output logic                      mem_write_finish,
    input  wire [31:0]                peek_addr,
    output logic [31:0]               peek_word,
    output int                        wb_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_geom_pkg::*;

    localparam int WORDS = 1024;   // 4 KB window, upper address bits ignored

    logic [31:0] mem [WORDS];
    logic [31:0] lfsr       = 32'd83084;
    logic [3:0]  draw       = '0;
    logic [1:0]  rd_gap     = '0;   // cycles until mem_rrdy
    logic [1:0]  wr_gap     = '0;   // cycles until mem_wrdy
    logic [1:0]  rd_delay   = '0;
    logic        rd_busy    = 1'b0;
    logic [31:0] rd_addr    = '0;
    logic        received_q = 1'b0;
    logic        rvalid_q   = 1'b0;
    logic        finish_q   = 1'b0;
    line_u       line_q     = '0;
    int          wb_q       = 0;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [3:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[2:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    assign mem_rrdy         = rd_gap == 2'd0;
    assign mem_wrdy         = wr_gap == 2'd0;
    assign mem_ren_received = received_q;
    assign mem_rvalid       = rvalid_q;
    assign mem_rdata        = line_q;
    assign mem_write_finish = finish_q;
    assign wb_count         = wb_q;
    assign peek_word        = mem[peek_addr[11:2]];

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < WORDS; i++)
                mem[i] <= ~(i * 4);   // each word holds its own byte address inverted
            lfsr = 32'd83084;
            rd_gap     <= '0;
            wr_gap     <= '0;
            rd_busy    <= 1'b0;
            received_q <= 1'b0;
            rvalid_q   <= 1'b0;
            finish_q   <= 1'b0;
            wb_q       <= 0;
        end
        else
        begin
            // ********************
            // ready gaps
            // ********************
            if (rd_gap != 2'd0)
                rd_gap <= rd_gap - 2'd1;
            else
            begin
                draw_bits(2, draw);
                rd_gap <= draw[1:0];
            end
            if (wr_gap != 2'd0)
                wr_gap <= wr_gap - 2'd1;
            else
            begin
                draw_bits(2, draw);
                wr_gap <= draw[1:0];
            end

            // ********************
            // line read
            // ********************
            received_q <= 1'b0;
            rvalid_q   <= 1'b0;
            if (mem_rd.ren && !rd_busy)
            begin
                rd_busy    <= 1'b1;
                rd_addr    <= mem_rd.raddr;
                received_q <= 1'b1;   // one cycle acknowledge
                draw_bits(2, draw);
                rd_delay <= draw[1:0];
            end
            else if (rd_busy && !received_q)
            begin
                if (rd_delay != 2'd0)
                    rd_delay <= rd_delay - 2'd1;
                else
                begin
                    for (int w = 0; w < WORDS_PER_LINE; w++)
                        line_q.words[w] <= mem[rd_addr[11:2] + w];
                    rvalid_q <= 1'b1;
                    rd_busy  <= 1'b0;
                end
            end

            // line write, finished one cycle later
            finish_q <= 1'b0;
            if (mem_wr.wen != 4'd0)
            begin
                for (int w = 0; w < WORDS_PER_LINE; w++)
                    mem[mem_wr.waddr[11:2] + w] <= mem_wr.wdata.words[w];
                wb_q     <= wb_q + 1;
                finish_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_dcache.sv
`default_nettype none

module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    localparam int SET_BITS = 2;     // four sets so conflicts come quickly
    localparam int MAX_OPS  = 64;
    localparam int TIMEOUT  = 200;   // cycles allowed per wait

    // op kinds of the data file
    localparam logic [31:0] OP_STORE    = 32'd0;
    localparam logic [31:0] OP_LOAD     = 32'd1;
    localparam logic [31:0] OP_LOAD_HIT = 32'd2;   // load that must hit
    localparam logic [31:0] OP_MEM      = 32'd3;   // memory word and write-back count

    logic        clk;
    logic        rst;
    cpu_req_t    req;
    logic        ready;
    logic [31:0] rdata;
    logic        rdata_valid;
    mem_rd_t     mem_rd;
    logic        mem_rrdy;
    logic        mem_ren_received;
    logic        mem_rvalid;
    line_u       mem_rdata;
    mem_wr_t     mem_wr;
    logic        mem_wrdy;
    logic        mem_write_finish;
    logic [31:0] peek_addr;
    logic [31:0] peek_word;
    int          wb_count;
    logic [31:0] ops [MAX_OPS*5];   // five words per op
    int          checks;
    int          mismatches;
    int          failures;

    dcache_top #(.SET_BITS(SET_BITS)) dcache_top_i (
        .clk(clk), .rst(rst), .req(req), .ready(ready), .rdata(rdata),
        .rdata_valid(rdata_valid), .mem_rd(mem_rd), .mem_rrdy(mem_rrdy),
        .mem_ren_received(mem_ren_received), .mem_rvalid(mem_rvalid),
        .mem_rdata(mem_rdata), .mem_wr(mem_wr), .mem_wrdy(mem_wrdy),
        .mem_write_finish(mem_write_finish)
    );

    tb_mem_model mem_i (
        .clk(clk), .rst(rst), .mem_rd(mem_rd), .mem_rrdy(mem_rrdy),
        .mem_ren_received(mem_ren_received), .mem_rvalid(mem_rvalid),
        .mem_rdata(mem_rdata), .mem_wr(mem_wr), .mem_wrdy(mem_wrdy),
        .mem_write_finish(mem_write_finish), .peek_addr(peek_addr),
        .peek_word(peek_word), .wb_count(wb_count)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            mismatches++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_ready(input string what, output logic ok);
        int n;
        n = 0;
        while (!ready && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        ok = ready;
        if (!ok)
        begin
            failures++;
            $display("timeout at %0t, ready stayed low %s", $time, what);
        end
    endtask

    // ********************
    // one op of the file
    // ********************
    task automatic run_op(input logic [31:0] kind, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] strb,
                          input logic [31:0] expected);
        logic ok;
        int   lat;
        if (kind == OP_MEM)
        begin
            peek_addr = addr;
            @(negedge clk);
            check_value("peek_word", peek_word, expected);
            check_value("wb_count", 32'(wb_count), data);
            return;
        end
        if (kind != OP_STORE && kind != OP_LOAD && kind != OP_LOAD_HIT)
        begin
            failures++;
            $display("unknown op kind %0d in dcache_tests.txt", kind);
            return;
        end
        wait_ready("before a request", ok);
        if (!ok)
            return;
        req.valid    = 1'b1;
        req.is_store = kind == OP_STORE;
        req.addr     = addr;
        req.wdata    = data;
        req.strb     = strb[3:0];
        @(posedge clk);   // accepted since ready was high
        @(negedge clk);
        req.valid = 1'b0;
        if (kind == OP_STORE)
        begin
            wait_ready("after a store", ok);
            return;
        end
        lat = 0;
        while (!rdata_valid && lat < TIMEOUT)
        begin
            if (kind == OP_LOAD_HIT)
                check_value("ready", 32'(ready), 32'd1);
            @(negedge clk);
            lat++;
        end
        if (!rdata_valid)
        begin
            failures++;
            $display("timeout at %0t, no rdata_valid for load of %h", $time, addr);
            return;
        end
        check_value("rdata", rdata, expected);
        if (kind == OP_LOAD_HIT)
            check_value("hit latency", 32'(lat), 32'd1);
        @(negedge clk);
        check_value("rdata_valid", 32'(rdata_valid), 32'd0);   // single pulse
    endtask

    initial
    begin
        int n;
        rst        = 1'b1;
        req        = '0;
        peek_addr  = '0;
        checks     = 0;
        mismatches = 0;
        failures   = 0;
        for (int i = 0; i < MAX_OPS*5; i++)
            ops[i] = '1;
        $readmemh("dcache_tests.txt", ops);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("ready", 32'(ready), 32'd1);
        check_value("rdata_valid", 32'(rdata_valid), 32'd0);
        check_value("mem_rd.ren", 32'(mem_rd.ren), 32'd0);
        check_value("mem_wr.wen", 32'(mem_wr.wen), 32'd0);
        if (ops[0] == 32'hffff_ffff)
        begin
            failures++;
            $display("no operations found in dcache_tests.txt");
        end
        n = 0;
        while (n < MAX_OPS && ops[n*5] != 32'hffff_ffff && failures == 0)
        begin
            run_op(ops[n*5], ops[n*5+1], ops[n*5+2], ops[n*5+3], ops[n*5+4]);
            n++;
        end
        $display("%0d ops, %0d checks, %0d value mismatches, %0d other failures",
                 n, checks, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache_tests.txt
// kind addr data strb expected, all hex
// kind 0 store, 1 load, 2 load that must hit, 3 memory word at addr (data = write-back count)
1 00000004 00000000 0 fffffffb // load miss, set 0 way 0
2 00000010 00000000 0 ffffffef // same line hits
0 00000008 aabbccdd 6 00000000 // partial store, bytes 1 and 2
2 00000008 00000000 0 ffbbccf7 // old bytes merged with stored ones
1 00000080 00000000 0 ffffff7f // second line of set 0, clean way 1
3 00000008 00000000 0 fffffff7 // nothing written back yet
1 00000100 00000000 0 fffffeff // third line evicts dirty way 0
3 00000008 00000001 0 ffbbccf7 // one write-back with stored bytes
1 00000008 00000000 0 ffbbccf7 // reload, evicts clean way 1
3 00000000 00000001 0 ffffffff // clean eviction wrote nothing
0 00000024 12345678 f 00000000 // store miss in set 1
2 00000024 00000000 0 12345678
0 00000024 99000000 8 00000000 // top byte only
2 00000024 00000000 0 99345678
1 000000a4 00000000 0 ffffff5b // set 1 way 1
1 00000124 00000000 0 fffffedb // evicts dirty line 0x20
3 00000024 00000002 0 99345678
3 00000028 00000002 0 ffffffd7 // rest of the line kept
1 00000024 00000000 0 99345678 // back from memory
2 00000104 00000000 0 fffffefb // set 0 line still cached
3 00000024 00000002 0 99345678

//--- build.f
cache_geom_pkg.sv
mem_bus_pkg.sv
dcache_way_ram.sv
dcache_lookup.sv
dcache_hit_stage.sv
dcache_miss_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module tb_dcache -o tb_dcache
	out="$$(./obj_dir/tb_dcache)"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
